//--- Bender.yml
package:
  name: mm_accel

sources:
  - rtl/mm_pkg.sv
  - rtl/axis_stream_if.sv
  - rtl/axis_fifo.sv
  - rtl/operand_ram.sv
  - rtl/mm_sequencer.sv
  - rtl/mac_engine.sv
  - rtl/mm_accel_top.sv
  - target: test
    files:
      - verif/tb_mm_accel.sv

//--- mm_accel.f
rtl/mm_pkg.sv
rtl/axis_stream_if.sv
rtl/axis_fifo.sv
rtl/operand_ram.sv
rtl/mm_sequencer.sv
rtl/mac_engine.sv
rtl/mm_accel_top.sv
verif/tb_mm_accel.sv

//--- rtl/axis_fifo.sv
/* Synchronous FIFO, one cycle from write to read; depth need not be a power of two
   Input tready stays low in reset and rises the cycle after release */
`timescale 1ns/1ps

module axis_fifo #(
    parameter type payload_t = logic [63:0],
    parameter int  depth     = 8
) (
    input  logic                       aclk,
    input  logic                       aresetn,
    axis_stream_if.sink                s,
    axis_stream_if.source              m,
    output logic [$clog2(depth+1)-1:0] count_o
);

    localparam int ptr_width = $clog2(depth);

    payload_t                   data_mem [depth];   // Payload storage
    logic                       last_mem [depth];   // tlast travels with its word
    logic [ptr_width-1:0]       wr_ptr_q;
    logic [ptr_width-1:0]       rd_ptr_q;
    logic [$clog2(depth+1)-1:0] count_q;
    logic                       live_q;             // Out of reset
    logic                       push;
    logic                       pop;

    assign s.tready = live_q && (count_q != depth);   // Not full
    assign m.tvalid = (count_q != '0);                // Not empty
    assign m.tdata  = data_mem[rd_ptr_q];
    assign m.tlast  = last_mem[rd_ptr_q];
    assign push     = s.tvalid && s.tready;
    assign pop      = m.tvalid && m.tready;
    assign count_o  = count_q;

    always_ff @(posedge aclk)
    begin
        if (push)
        begin
            data_mem[wr_ptr_q] <= s.tdata;
            last_mem[wr_ptr_q] <= s.tlast;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            live_q   <= 1'b0;
        end
        else
        begin
            live_q <= 1'b1;
            if (push)
                wr_ptr_q <= (wr_ptr_q == ptr_width'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= (rd_ptr_q == ptr_width'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;       // Both or neither
            endcase
        end
    end

    // Fill level within the storage and pointers met when full
    count_in_range: assert property (@(posedge aclk) disable iff (!aresetn)
        (count_q <= depth) && ((count_q != depth) || (wr_ptr_q == rd_ptr_q)));

    // An empty count leaves no word behind the read pointer
    count_no_underflow: assert property (@(posedge aclk) disable iff (!aresetn)
        (count_q == '0) |-> (wr_ptr_q == rd_ptr_q));

endmodule

//--- rtl/axis_stream_if.sv
/* Ready/valid stream; a transfer needs tvalid and tready high on a rising aclk
   The source holds tdata and tlast from tvalid rise until the transfer */
`timescale 1ns/1ps

interface axis_stream_if #(
    parameter type payload_t = logic [63:0]
);

    payload_t tdata;    // Payload word
    logic     tvalid;   // Source has a word
    logic     tready;   // Sink takes it
    logic     tlast;    // End of packet

    modport source (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    modport sink (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

//--- rtl/mac_engine.sv
/* Three cycles per C element (address, read, multiply-add), one row offered at a time
   A stalled row freezes the engine; done pulses after row 7 is taken */
`timescale 1ns/1ps

module mac_engine (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  start_i,
    output logic                  done_o,
    output mm_pkg::a_addr_t       a_raddr_o,
    input  mm_pkg::operand_word_t a_rdata_i,
    output mm_pkg::w_addr_t       w_raddr_o,
    input  mm_pkg::operand_word_t w_rdata_i,
    axis_stream_if.source         c_out
);

    typedef enum logic [2:0] {st_idle, st_addr, st_read, st_mac, st_offer} state_t;

    state_t               state_q;
    mm_pkg::a_addr_t      row_q;                         // C row index
    mm_pkg::w_addr_t      col_q;                         // C column index
    mm_pkg::prod_t        prod_q [mm_pkg::inner_dim];    // Full products
    mm_pkg::result_word_t row_buf_q;                     // Row under assembly
    mm_pkg::acc_t         sum;
    mm_pkg::acc_t         scaled;
    mm_pkg::elem_t        sat;
    logic                 row_xfer;                      // Row taken by the FIFO

    assign a_raddr_o    = row_q;
    assign w_raddr_o    = col_q;
    assign c_out.tvalid = (state_q == st_offer);
    assign c_out.tdata  = row_buf_q;
    assign c_out.tlast  = (row_q == mm_pkg::a_rows - 1);   // Last row of the product
    assign row_xfer     = c_out.tvalid && c_out.tready;

    // Sum, floor shift, clamp
    always_comb
    begin
        sum = '0;
        for (int k = 0; k < mm_pkg::inner_dim; k++)
            sum = sum + mm_pkg::acc_t'(prod_q[k]);   // Sign extended
        scaled = sum >>> mm_pkg::frac_width;         // Arithmetic, rounds to floor
        if (scaled > mm_pkg::elem_max)
            sat = mm_pkg::elem_max;
        else if (scaled < mm_pkg::elem_min)
            sat = mm_pkg::elem_min;
        else
            sat = mm_pkg::elem_t'(scaled);
    end

    // Datapath
    always_ff @(posedge aclk)
    begin
        if (state_q == st_read)
        begin
            for (int k = 0; k < mm_pkg::inner_dim; k++)
                prod_q[k] <= $signed(a_rdata_i[k*mm_pkg::elem_width +: mm_pkg::elem_width])
                           * $signed(w_rdata_i[k*mm_pkg::elem_width +: mm_pkg::elem_width]);
        end
        if (state_q == st_mac)
            row_buf_q[col_q*mm_pkg::elem_width +: mm_pkg::elem_width] <= sat;
    end

    // Control
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state_q <= st_idle;
            row_q   <= '0;
            col_q   <= '0;
            done_o  <= 1'b0;
        end
        else
        begin
            done_o <= row_xfer && c_out.tlast;
            case (state_q)
                st_idle:  if (start_i) state_q <= st_addr;
                st_addr:  state_q <= st_read;   // RAMs latch the addresses
                st_read:  state_q <= st_mac;
                st_mac:
                begin
                    if (col_q == mm_pkg::w_cols - 1)
                    begin
                        col_q   <= '0;
                        state_q <= st_offer;
                    end
                    else
                    begin
                        col_q   <= col_q + 1'b1;
                        state_q <= st_addr;
                    end
                end
                st_offer:
                begin
                    if (row_xfer)
                    begin
                        row_q   <= row_q + 1'b1;   // Wraps to 0 after row 7
                        state_q <= c_out.tlast ? st_idle : st_addr;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // Offered row held under back-pressure
    c_row_held: assert property (@(posedge aclk) disable iff (!aresetn)
        c_out.tvalid && !c_out.tready |=> c_out.tvalid && $stable(c_out.tdata));

endmodule

//--- rtl/mm_accel_top.sv
/* Fixed-point C = A x W accelerator; A rows and W columns in, C rows out
   Incoming tlast is ignored; result tlast marks row 7 of each product */
`timescale 1ns/1ps

module mm_accel_top (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  mm_pkg::operand_word_t s_axis_a_tdata_i,
    input  logic                  s_axis_a_tvalid_i,
    input  logic                  s_axis_a_tlast_i,
    output logic                  s_axis_a_tready_o,
    input  mm_pkg::operand_word_t s_axis_w_tdata_i,
    input  logic                  s_axis_w_tvalid_i,
    input  logic                  s_axis_w_tlast_i,
    output logic                  s_axis_w_tready_o,
    output mm_pkg::result_word_t  m_axis_c_tdata_o,
    output logic                  m_axis_c_tvalid_o,
    output logic                  m_axis_c_tlast_o,
    input  logic                  m_axis_c_tready_i
);

    axis_stream_if #(.payload_t(mm_pkg::operand_word_t)) a_port ();   // Boundary
    axis_stream_if #(.payload_t(mm_pkg::operand_word_t)) w_port ();
    axis_stream_if #(.payload_t(mm_pkg::result_word_t))  c_port ();
    axis_stream_if #(.payload_t(mm_pkg::operand_word_t)) a_stream ();  // Internal
    axis_stream_if #(.payload_t(mm_pkg::operand_word_t)) w_stream ();
    axis_stream_if #(.payload_t(mm_pkg::result_word_t))  c_stream ();

    logic [$clog2(mm_pkg::a_rows+1)-1:0] a_count;
    logic [$clog2(mm_pkg::w_cols+1)-1:0] w_count;
    logic                  a_we;
    mm_pkg::a_addr_t       a_waddr;
    mm_pkg::operand_word_t a_wdata;
    logic                  w_we;
    mm_pkg::w_addr_t       w_waddr;
    mm_pkg::operand_word_t w_wdata;
    mm_pkg::a_addr_t       a_raddr;
    mm_pkg::operand_word_t a_rdata;
    mm_pkg::w_addr_t       w_raddr;
    mm_pkg::operand_word_t w_rdata;
    logic                  start;
    logic                  done;

    assign a_port.tdata      = s_axis_a_tdata_i;
    assign a_port.tvalid     = s_axis_a_tvalid_i;
    assign a_port.tlast      = s_axis_a_tlast_i;
    assign s_axis_a_tready_o = a_port.tready;
    assign w_port.tdata      = s_axis_w_tdata_i;
    assign w_port.tvalid     = s_axis_w_tvalid_i;
    assign w_port.tlast      = s_axis_w_tlast_i;
    assign s_axis_w_tready_o = w_port.tready;
    assign m_axis_c_tdata_o  = c_port.tdata;
    assign m_axis_c_tvalid_o = c_port.tvalid;
    assign m_axis_c_tlast_o  = c_port.tlast;
    assign c_port.tready     = m_axis_c_tready_i;

    axis_fifo #(.payload_t(mm_pkg::operand_word_t), .depth(mm_pkg::a_rows)) u_a_fifo (
        .aclk(aclk), .aresetn(aresetn), .s(a_port), .m(a_stream), .count_o(a_count));

    axis_fifo #(.payload_t(mm_pkg::operand_word_t), .depth(mm_pkg::w_cols)) u_w_fifo (
        .aclk(aclk), .aresetn(aresetn), .s(w_port), .m(w_stream), .count_o(w_count));

    axis_fifo #(.payload_t(mm_pkg::result_word_t), .depth(mm_pkg::a_rows)) u_c_fifo (
        .aclk(aclk), .aresetn(aresetn), .s(c_stream), .m(c_port), .count_o());

    operand_ram #(.payload_t(mm_pkg::operand_word_t), .depth(mm_pkg::a_rows)) u_a_ram (
        .aclk(aclk), .we_i(a_we), .waddr_i(a_waddr), .wdata_i(a_wdata),
        .raddr_i(a_raddr), .rdata_o(a_rdata));

    operand_ram #(.payload_t(mm_pkg::operand_word_t), .depth(mm_pkg::w_cols)) u_w_ram (
        .aclk(aclk), .we_i(w_we), .waddr_i(w_waddr), .wdata_i(w_wdata),
        .raddr_i(w_raddr), .rdata_o(w_rdata));

    mm_sequencer u_sequencer (
        .aclk(aclk), .aresetn(aresetn),
        .a_in(a_stream), .a_count_i(a_count),
        .w_in(w_stream), .w_count_i(w_count),
        .a_we_o(a_we), .a_waddr_o(a_waddr), .a_wdata_o(a_wdata),
        .w_we_o(w_we), .w_waddr_o(w_waddr), .w_wdata_o(w_wdata),
        .start_o(start), .done_i(done));

    mac_engine u_engine (
        .aclk(aclk), .aresetn(aresetn), .start_i(start), .done_o(done),
        .a_raddr_o(a_raddr), .a_rdata_i(a_rdata),
        .w_raddr_o(w_raddr), .w_rdata_i(w_rdata),
        .c_out(c_stream));

endmodule

//--- rtl/mm_pkg.sv
/* Q8.8 definitions for C = A x W with A 8x4 and W 4x6
   Element k of a packed word sits at bits 16k upward */
package mm_pkg;

    localparam int elem_width = 16;               // Bits per element
    localparam int frac_width = 8;                // Fraction bits, also the result shift
    localparam int inner_dim  = 4;                // Elements per A row and W column
    localparam int a_rows     = 8;                // Rows of A and of C
    localparam int w_cols     = 6;                // Columns of W and of C
    localparam int prod_width = 2 * elem_width;   // Full signed product
    localparam int acc_width  = prod_width + 2;   // Headroom for four products

    typedef logic signed [elem_width-1:0]    elem_t;
    typedef logic [inner_dim*elem_width-1:0] operand_word_t;   // One A row or W column
    typedef logic [w_cols*elem_width-1:0]    result_word_t;    // One C row
    typedef logic signed [prod_width-1:0]    prod_t;
    typedef logic signed [acc_width-1:0]     acc_t;
    typedef logic [$clog2(a_rows)-1:0]       a_addr_t;
    typedef logic [$clog2(w_cols)-1:0]       w_addr_t;         // Also reaches w_cols in load

    // Saturation bounds of the result
    localparam elem_t elem_max = 16'sh7fff;
    localparam elem_t elem_min = 16'sh8000;

endpackage

//--- rtl/mm_sequencer.sv
/* Loads only once both FIFOs hold a full operand set, so a load never stalls
   Incoming tlast is ignored; words land in memory in arrival order */
`timescale 1ns/1ps

module mm_sequencer (
    input  logic                                aclk,
    input  logic                                aresetn,
    axis_stream_if.sink                         a_in,
    input  logic [$clog2(mm_pkg::a_rows+1)-1:0] a_count_i,
    axis_stream_if.sink                         w_in,
    input  logic [$clog2(mm_pkg::w_cols+1)-1:0] w_count_i,
    output logic                                a_we_o,
    output mm_pkg::a_addr_t                     a_waddr_o,
    output mm_pkg::operand_word_t               a_wdata_o,
    output logic                                w_we_o,
    output mm_pkg::w_addr_t                     w_waddr_o,
    output mm_pkg::operand_word_t               w_wdata_o,
    output logic                                start_o,
    input  logic                                done_i
);

    typedef enum logic [1:0] {st_idle, st_load, st_compute} state_t;

    state_t          state_q;
    mm_pkg::a_addr_t a_idx_q;          // A row being loaded
    mm_pkg::w_addr_t w_idx_q;          // W column being loaded, stops at w_cols
    logic            operands_ready;   // Full set waiting in both FIFOs
    logic            w_pending;        // W columns still to pop
    logic            load_last;        // Final load cycle

    assign operands_ready = (a_count_i >= mm_pkg::a_rows) && (w_count_i >= mm_pkg::w_cols);
    assign w_pending      = (w_idx_q < mm_pkg::w_cols);
    assign load_last      = (state_q == st_load) && (a_idx_q == mm_pkg::a_rows - 1);

    // Pop and write in the same cycle
    assign a_in.tready = (state_q == st_load);
    assign w_in.tready = (state_q == st_load) && w_pending;
    assign a_we_o      = a_in.tready;
    assign a_waddr_o   = a_idx_q;
    assign a_wdata_o   = a_in.tdata;
    assign w_we_o      = w_in.tready;
    assign w_waddr_o   = w_idx_q;
    assign w_wdata_o   = w_in.tdata;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state_q <= st_idle;
            a_idx_q <= '0;
            w_idx_q <= '0;
            start_o <= 1'b0;
        end
        else
        begin
            start_o <= load_last;   // Pulse right after the load
            case (state_q)
                st_idle:
                begin
                    if (operands_ready)
                        state_q <= st_load;
                end
                st_load:
                begin
                    a_idx_q <= a_idx_q + 1'b1;   // Wraps to 0 after row 7
                    if (w_pending)
                        w_idx_q <= w_idx_q + 1'b1;
                    if (load_last)
                    begin
                        state_q <= st_compute;
                        w_idx_q <= '0;
                    end
                end
                st_compute:
                begin
                    if (done_i)   // Back-to-back load if the next set is in
                        state_q <= operands_ready ? st_load : st_idle;
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // Counts seen in idle guarantee data behind every pop
    a_pop_has_data: assert property (@(posedge aclk) disable iff (!aresetn)
        a_in.tready |-> a_in.tvalid);

    w_pop_has_data: assert property (@(posedge aclk) disable iff (!aresetn)
        w_in.tready |-> w_in.tvalid);

endmodule

//--- rtl/operand_ram.sv
/* Simple dual-port memory with registered read, data one cycle after the address
   No reset, contents are valid only after the sequencer has loaded them */
`timescale 1ns/1ps

module operand_ram #(
    parameter type payload_t = logic [63:0],
    parameter int  depth     = 8
) (
    input  logic                     aclk,
    input  logic                     we_i,
    input  logic [$clog2(depth)-1:0] waddr_i,
    input  payload_t                 wdata_i,
    input  logic [$clog2(depth)-1:0] raddr_i,
    output payload_t                 rdata_o
);

    payload_t mem [depth];   // Block RAM

    always_ff @(posedge aclk)
    begin
        if (we_i)
            mem[waddr_i] <= wdata_i;   // Write port from the sequencer
        rdata_o <= mem[raddr_i];       // Read port from the engine
    end

endmodule

//--- verif/tb_mm_accel.sv
/* Random products checked row by row against a Q8.8 model; products 0 to 2 saturate
   Product 3 sends W before A, product 4 uses long input gaps, results of 5 stall */
`timescale 1ns/1ps

module tb_mm_accel;

    localparam int num_products       = 20;
    localparam int cycles_per_product = 400;
    localparam int cycle_limit        = num_products * cycles_per_product + 200;
    localparam int stall_product      = 5;     // Its rows are held back
    localparam int stall_cycles       = 300;   // Long enough to stall engine and inputs

    logic                  aclk;
    logic                  aresetn;
    mm_pkg::operand_word_t s_axis_a_tdata_i;
    logic                  s_axis_a_tvalid_i;
    logic                  s_axis_a_tlast_i;
    logic                  s_axis_a_tready_o;
    mm_pkg::operand_word_t s_axis_w_tdata_i;
    logic                  s_axis_w_tvalid_i;
    logic                  s_axis_w_tlast_i;
    logic                  s_axis_w_tready_o;
    mm_pkg::result_word_t  m_axis_c_tdata_o;
    logic                  m_axis_c_tvalid_o;
    logic                  m_axis_c_tlast_o;
    logic                  m_axis_c_tready_i;

    integer                seed;                           // Stimulus
    integer                ready_seed;                     // Back-pressure, own stream
    mm_pkg::operand_word_t a_mat [mm_pkg::a_rows];         // Current product
    mm_pkg::operand_word_t w_mat [mm_pkg::w_cols];
    int                    a_gap [mm_pkg::a_rows];         // Idle cycles before each word
    int                    w_gap [mm_pkg::w_cols];
    mm_pkg::result_word_t  exp_q [$];                      // Expected C rows in order
    mm_pkg::result_word_t  exp_row;
    int                    value_errors    = 0;
    int                    protocol_errors = 0;
    int                    rows_seen       = 0;
    int                    products_seen   = 0;
    int                    row_in_prod     = 0;
    int                    cycles          = 0;
    int                    sets_sent       = 0;            // Complete operand sets pushed
    int                    stall_count     = 0;            // Valid cycles held back so far

    mm_accel_top u_dut (.*);

    always #20 aclk = ~aclk;   // 40 ns period

    // One element of C row r: four products, floor shift, clamp
    function automatic mm_pkg::result_word_t model_row(input int r);
        longint               sum;
        longint               scaled;
        mm_pkg::result_word_t row;
        for (int c = 0; c < mm_pkg::w_cols; c++)
        begin
            sum = 0;
            for (int k = 0; k < mm_pkg::inner_dim; k++)
                sum += longint'($signed(a_mat[r][k*16 +: 16]))
                     * longint'($signed(w_mat[c][k*16 +: 16]));
            scaled = sum >>> 8;                              // Floor toward minus infinity
            if (scaled > 32767)
                scaled = 32767;
            else if (scaled < -32768)
                scaled = -32768;
            row[c*16 +: 16] = 16'(scaled);
        end
        return row;
    endfunction

    function automatic mm_pkg::elem_t pick_elem(input int p);
        int r;
        r = $random(seed);
        case (p)
            0:       return 16'h7fff;                        // Positive overflow
            1:       return 16'h8000;                        // Most negative squared
            2:       return r[0] ? 16'h7fff : 16'h8000;      // Mixed signs
            default: return (p % 2) ? mm_pkg::elem_t'(r) : (mm_pkg::elem_t'(r) >>> 6);
        endcase
    endfunction

    task automatic build_product(input int p);
        for (int r = 0; r < mm_pkg::a_rows; r++)
        begin
            for (int k = 0; k < mm_pkg::inner_dim; k++)
                a_mat[r][k*16 +: 16] = pick_elem(p);
            a_gap[r] = (p == 4) ? ($random(seed) & 31) : ($random(seed) & 3);
        end
        for (int c = 0; c < mm_pkg::w_cols; c++)
        begin
            for (int k = 0; k < mm_pkg::inner_dim; k++)
                w_mat[c][k*16 +: 16] = pick_elem(p);
            w_gap[c] = (p == 4) ? ($random(seed) & 31) : ($random(seed) & 3);
        end
        for (int r = 0; r < mm_pkg::a_rows; r++)
            exp_q.push_back(model_row(r));
    endtask

    // tready seen at a falling edge holds through the next rising edge
    task automatic send_a_rows();
        for (int r = 0; r < mm_pkg::a_rows; r++)
        begin
            repeat (a_gap[r]) @(negedge aclk);
            s_axis_a_tdata_i  = a_mat[r];
            s_axis_a_tlast_i  = (r == mm_pkg::a_rows - 1);
            s_axis_a_tvalid_i = 1'b1;
            while (!s_axis_a_tready_o)
                @(negedge aclk);
            @(negedge aclk);
            s_axis_a_tvalid_i = 1'b0;
        end
    endtask

    task automatic send_w_cols();
        for (int c = 0; c < mm_pkg::w_cols; c++)
        begin
            repeat (w_gap[c]) @(negedge aclk);
            s_axis_w_tdata_i  = w_mat[c];
            s_axis_w_tlast_i  = (c == mm_pkg::w_cols - 1);
            s_axis_w_tvalid_i = 1'b1;
            while (!s_axis_w_tready_o)
                @(negedge aclk);
            @(negedge aclk);
            s_axis_w_tvalid_i = 1'b0;
        end
    endtask

    task automatic report_and_finish();
        $display("errors: %0d mismatch, %0d other; %0d rows, %0d products received",
                 value_errors, protocol_errors, rows_seen, products_seen);
        if (value_errors + protocol_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    endtask

    // Back-pressure and result check; a transfer happens at the coming rising edge
    always @(negedge aclk)
    begin
        if (products_seen == stall_product && stall_count < stall_cycles)
        begin
            m_axis_c_tready_i = 1'b0;                        // Result FIFO fills, engine stalls
            if (m_axis_c_tvalid_o === 1'b1)
                stall_count++;
        end
        else
            m_axis_c_tready_i = aresetn && (($random(ready_seed) & 3) != 0);
        if (m_axis_c_tvalid_o === 1'b1 && products_seen >= sets_sent)
        begin
            protocol_errors++;
            $display("Result valid before its full operand set was sent");
        end
        if (m_axis_c_tvalid_o === 1'b1 && m_axis_c_tready_i)
        begin
            if (exp_q.size() == 0)
            begin
                protocol_errors++;
                $display("Result row arrived with no row expected");
            end
            else
            begin
                exp_row = exp_q.pop_front();
                if (m_axis_c_tdata_o !== exp_row)
                begin
                    value_errors++;
                    $display("MISMATCH m_axis_c_tdata_o product %0d row %0d: got %h expected %h",
                             products_seen, row_in_prod, m_axis_c_tdata_o, exp_row);
                end
            end
            if (m_axis_c_tlast_o !== (row_in_prod == mm_pkg::a_rows - 1))
            begin
                value_errors++;
                $display("MISMATCH m_axis_c_tlast_o product %0d row %0d: got %h expected %h",
                         products_seen, row_in_prod, m_axis_c_tlast_o,
                         row_in_prod == mm_pkg::a_rows - 1);
            end
            rows_seen++;
            if (m_axis_c_tlast_o === 1'b1)
                products_seen++;
            row_in_prod = (row_in_prod + 1) % mm_pkg::a_rows;
        end
    end

    always @(posedge aclk)
    begin
        cycles++;
        if (cycles >= cycle_limit)
        begin
            protocol_errors++;
            $display("Timeout after %0d cycles with %0d of %0d rows received",
                     cycles, rows_seen, num_products * mm_pkg::a_rows);
            report_and_finish();
        end
    end

    initial
    begin
        seed              = 32'h7167_c9ed;
        ready_seed        = 32'h7167_c9ed + 1;
        aclk              = 1'b0;
        aresetn           = 1'b0;
        s_axis_a_tdata_i  = '0;
        s_axis_a_tvalid_i = 1'b0;
        s_axis_a_tlast_i  = 1'b0;
        s_axis_w_tdata_i  = '0;
        s_axis_w_tvalid_i = 1'b0;
        s_axis_w_tlast_i  = 1'b0;
        m_axis_c_tready_i = 1'b0;
        repeat (16) @(negedge aclk);
        aresetn = 1'b1;
        for (int p = 0; p < num_products; p++)
        begin
            build_product(p);
            if (p == 3)
            begin
                send_w_cols();   // All weights before any input row
                send_a_rows();
            end
            else
            begin
                fork
                    send_a_rows();
                    send_w_cols();
                join
            end
            sets_sent++;
        end
        wait (rows_seen == num_products * mm_pkg::a_rows);
        repeat (20) @(negedge aclk);   // Catch any extra row
        if (products_seen != num_products || exp_q.size() != 0)
        begin
            protocol_errors++;
            $display("Product count wrong: %0d received of %0d sent, %0d rows left",
                     products_seen, num_products, exp_q.size());
        end
        report_and_finish();
    end

endmodule
